// File: hdl/vec_instr_fifo.sv
//////////////////////////////////////////////////
// Circular instruction FIFO, depth from the package
// Push into a full FIFO and pop from an empty one are ignored
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_instr_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  vec_issue_pkg::instr_t data_i,
  input  logic                  pop_i,
  output vec_issue_pkg::instr_t data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  import vec_issue_pkg::*;

  localparam logic [FifoPtrWidth-1:0] LastIdx = FifoPtrWidth'(FifoDepth - 1);
  localparam logic [FifoPtrWidth:0]   MaxCnt  = (FifoPtrWidth + 1)'(FifoDepth);

  instr_t                  mem_q [FifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q, wr_ptr_d;
  logic [FifoPtrWidth-1:0] rd_ptr_q, rd_ptr_d;
  logic [FifoPtrWidth:0]   cnt_q, cnt_d;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (cnt_q == MaxCnt);
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  //////////////////////////////////////////////////
  // Pointer and count update
  //////////////////////////////////////////////////

  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;

    if (do_push) begin
      wr_ptr_d = (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
    end
    if (do_pop) begin
      rd_ptr_d = (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
    end

    // Simultaneous push and pop keep the count
    if (do_push && !do_pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (do_pop && !do_push) begin
      cnt_d = cnt_q - 1'b1;
    end

    // Flush wins over everything
    if (flush_i) begin
      wr_ptr_d = '0;
      rd_ptr_d = '0;
      cnt_d    = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : vec_instr_fifo

`default_nettype wire

// File: hdl/vec_issue_frontend.sv
//////////////////////////////////////////////////
// Issue front end of the vector coprocessor
// Issue to register ready takes two cycles on an empty FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_issue_frontend (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issue side
  input  logic                  issue_valid_i,
  input  vec_issue_pkg::instr_t issue_instr_i,
  output logic                  issue_ready_o,
  output logic                  issue_accept_o,
  // Register side
  input  logic                  register_valid_i,
  input  vec_issue_pkg::xlen_t  rs1_i,
  input  vec_issue_pkg::xlen_t  rs2_i,
  output logic                  register_ready_o,
  // Dispatch side
  output logic                  dispatch_valid_o,
  output vec_issue_pkg::instr_t dispatch_instr_o,
  output vec_issue_pkg::xlen_t  dispatch_rs1_o,
  output vec_issue_pkg::xlen_t  dispatch_rs2_o,
  // Flush control
  input  logic                  flush_i,
  input  logic                  flush_unissued_i
);

  import vec_issue_pkg::*;

  logic   accept;
  instr_t head_instr;
  logic   fifo_nonempty;
  logic   pop;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  vec_lw_decoder i_decoder (
    .instr_i  (issue_instr_i),
    .accept_o (accept       )
  );

  assign issue_accept_o = accept;

  //////////////////////////////////////////////////
  // Pre-buffer and FIFO
  //////////////////////////////////////////////////

  vec_issue_queue i_queue (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .issue_valid_i    (issue_valid_i   ),
    .issue_instr_i    (issue_instr_i   ),
    .accept_i         (accept          ),
    .flush_i          (flush_i         ),
    .flush_unissued_i (flush_unissued_i),
    .pop_i            (pop             ),
    .issue_ready_o    (issue_ready_o   ),
    .head_instr_o     (head_instr      ),
    .nonempty_o       (fifo_nonempty   )
  );

  // Operands and dispatch
  vec_operand_stage i_operand_stage (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .register_valid_i (register_valid_i),
    .rs1_i            (rs1_i           ),
    .rs2_i            (rs2_i           ),
    .head_instr_i     (head_instr      ),
    .nonempty_i       (fifo_nonempty   ),
    .register_ready_o (register_ready_o),
    .pop_o            (pop             ),
    .dispatch_valid_o (dispatch_valid_o),
    .dispatch_instr_o (dispatch_instr_o),
    .dispatch_rs1_o   (dispatch_rs1_o  ),
    .dispatch_rs2_o   (dispatch_rs2_o  )
  );

endmodule : vec_issue_frontend

`default_nettype wire

// File: hdl/vec_issue_pkg.sv
//////////////////////////////////////////////////
// Shared widths, opcodes and state encodings of the issue front end
// The FIFO depth is fixed here and is not a module parameter
//////////////////////////////////////////////////

`default_nettype none

package vec_issue_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned InstrWidth   = 32;
  localparam int unsigned XlenWidth    = 64;
  localparam int unsigned FifoDepth    = 4;
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);

  // Instruction fields used by the decoder
  localparam int unsigned OpcodeWidth  = 7;
  localparam int unsigned VwidthWidth  = 3;
  localparam int unsigned VwidthLsb    = 12;

  typedef logic [InstrWidth-1:0] instr_t;
  typedef logic [XlenWidth-1:0]  xlen_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Major opcodes the coprocessor cares about
  typedef enum logic [OpcodeWidth-1:0] {
    OPC_LOAD_FP  = 7'h07,
    OPC_STORE_FP = 7'h27,
    OPC_OP_V     = 7'h57
  } opcode_e;

  // Vector element widths of the memory width field
  // Scalar FP widths 1 to 4 are left out on purpose
  typedef enum logic [VwidthWidth-1:0] {
    VW_E8  = 3'd0,
    VW_E16 = 3'd5,
    VW_E32 = 3'd6,
    VW_E64 = 3'd7
  } vwidth_e;

  // Dispatch register state
  typedef enum logic {
    DISP_EMPTY = 1'b0,
    DISP_VALID = 1'b1
  } disp_state_e;

endpackage : vec_issue_pkg

`default_nettype wire

// File: hdl/vec_issue_queue.sv
//////////////////////////////////////////////////
// One-entry pre-buffer in front of the instruction FIFO
// Flush-unissued also drops an instruction taken in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_issue_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_valid_i,
  input  vec_issue_pkg::instr_t issue_instr_i,
  input  logic                  accept_i,
  input  logic                  flush_i,
  input  logic                  flush_unissued_i,
  input  logic                  pop_i,
  output logic                  issue_ready_o,
  output vec_issue_pkg::instr_t head_instr_o,
  output logic                  nonempty_o
);

  import vec_issue_pkg::*;

  instr_t pre_instr_q;
  logic   pre_full_q, pre_full_d;
  logic   new_instr;
  logic   push;
  logic   fifo_full;
  logic   fifo_empty;

  // No new instruction while the FIFO is full or being flushed
  assign issue_ready_o = issue_valid_i && !fifo_full && !flush_i;
  assign new_instr     = issue_valid_i && issue_ready_o && accept_i;

  //////////////////////////////////////////////////
  // Pre-buffer control
  //////////////////////////////////////////////////

  always_comb begin
    push       = 1'b0;
    pre_full_d = pre_full_q;

    // Drain into the FIFO when there is room
    if (pre_full_q && !fifo_full) begin
      push       = 1'b1;
      pre_full_d = 1'b0;
    end

    // Refill on the same edge
    if (new_instr) begin
      pre_full_d = 1'b1;
    end

    if (flush_unissued_i || flush_i) begin
      push       = 1'b0;
      pre_full_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pre_full_q <= 1'b0;
    end else begin
      pre_full_q <= pre_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_instr) begin
      pre_instr_q <= issue_instr_i;
    end
  end

  vec_instr_fifo i_fifo (
    .clk_i   (clk_i       ),
    .rst_ni  (rst_ni      ),
    .flush_i (flush_i     ),
    .push_i  (push        ),
    .data_i  (pre_instr_q ),
    .pop_i   (pop_i       ),
    .data_o  (head_instr_o),
    .full_o  (fifo_full   ),
    .empty_o (fifo_empty  )
  );

  assign nonempty_o = !fifo_empty;

endmodule : vec_issue_queue

`default_nettype wire

// File: hdl/vec_lw_decoder.sv
//////////////////////////////////////////////////
// Light-weight accept/reject decode, purely combinational
// Only opcode and width field are inspected
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_lw_decoder (
  input  vec_issue_pkg::instr_t instr_i,
  output logic                  accept_o
);

  import vec_issue_pkg::*;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  opcode_e opcode;
  vwidth_e vwidth;
  logic    vec_width;

  // Major opcode sits in the low bits
  assign opcode = opcode_e'(instr_i[OpcodeWidth-1:0]);

  // Width field of loads and stores
  assign vwidth = vwidth_e'(instr_i[VwidthLsb +: VwidthWidth]);

  //////////////////////////////////////////////////
  // Width check
  //////////////////////////////////////////////////

  always_comb begin
    vec_width = 1'b0;
    case (vwidth)
      VW_E8,
      VW_E16,
      VW_E32,
      VW_E64: begin
        vec_width = 1'b1;
      end
      default: begin
        // Scalar FP load/store, belongs to the core
        vec_width = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Verdict
  //////////////////////////////////////////////////

  always_comb begin
    accept_o = 1'b0;
    case (opcode)
      OPC_OP_V: begin
        accept_o = 1'b1;
      end
      OPC_LOAD_FP,
      OPC_STORE_FP: begin
        accept_o = vec_width;
      end
      default: begin
        accept_o = 1'b0;
      end
    endcase
  end

endmodule : vec_lw_decoder

`default_nettype wire

// File: hdl/vec_operand_stage.sv
//////////////////////////////////////////////////
// Pairs the FIFO head with core operands for dispatch
// Dispatch has no back-pressure, valid lasts one cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_operand_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  register_valid_i,
  input  vec_issue_pkg::xlen_t  rs1_i,
  input  vec_issue_pkg::xlen_t  rs2_i,
  input  vec_issue_pkg::instr_t head_instr_i,
  input  logic                  nonempty_i,
  output logic                  register_ready_o,
  output logic                  pop_o,
  output logic                  dispatch_valid_o,
  output vec_issue_pkg::instr_t dispatch_instr_o,
  output vec_issue_pkg::xlen_t  dispatch_rs1_o,
  output vec_issue_pkg::xlen_t  dispatch_rs2_o
);

  import vec_issue_pkg::*;

  disp_state_e state_q, state_d;
  instr_t      instr_q;
  xlen_t       rs1_q;
  xlen_t       rs2_q;

  // Operands are wanted as long as something is queued
  assign register_ready_o = nonempty_i;
  assign pop_o            = register_valid_i && register_ready_o;

  // One-cycle strobe per pop
  assign state_d = pop_o ? DISP_VALID : DISP_EMPTY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DISP_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture instruction with its operands
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      instr_q <= head_instr_i;
      rs1_q   <= rs1_i;
      rs2_q   <= rs2_i;
    end
  end

  assign dispatch_valid_o = (state_q == DISP_VALID);
  assign dispatch_instr_o = instr_q;
  assign dispatch_rs1_o   = rs1_q;
  assign dispatch_rs2_o   = rs2_q;

endmodule : vec_operand_stage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the issue front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_vec_issue -Mdir obj_dir

# The log decides the result, not the exit code of the simulation
./obj_dir/Vtb_vec_issue > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation done"

// File: src.f
hdl/vec_issue_pkg.sv
hdl/vec_lw_decoder.sv
hdl/vec_instr_fifo.sv
hdl/vec_issue_queue.sv
hdl/vec_operand_stage.sv
hdl/vec_issue_frontend.sv
test/tb_clock_gen.sv
test/tb_vec_issue.sv

// File: test/tb_clock_gen.sv
//////////////////////////////////////////////////
// Free-running 100 ns clock, reset low for 4 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 50;
  localparam int ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Release on a rising edge, seen by the DUT one edge later
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: test/tb_vec_issue.sv
//////////////////////////////////////////////////
// Table-driven testbench with a cycle model of the queue
// The run stops at the first mismatch
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vec_issue;

  import vec_issue_pkg::*;

  localparam int ActNone  = 0;
  localparam int ActDrain = 1;
  localparam int ActFlush = 2;
  localparam int ActUniss = 3;
  localparam int MaxHeld  = 5;

  typedef struct {
    string  name;
    instr_t instr;
    logic   accept;
    logic   hold;
    int     action;
    xlen_t  rs1;
    xlen_t  rs2;
  } row_t;

  typedef struct {
    string  name;
    instr_t instr;
  } entry_t;

  logic   clk;
  logic   rst_n;
  logic   issue_valid;
  instr_t issue_instr;
  logic   issue_ready;
  logic   issue_accept;
  logic   register_valid;
  xlen_t  rs1;
  xlen_t  rs2;
  logic   register_ready;
  logic   dispatch_valid;
  instr_t dispatch_instr;
  xlen_t  dispatch_rs1;
  xlen_t  dispatch_rs2;
  logic   flush;
  logic   flush_unissued;

  // Reference state is updated on the falling edge for the next rising edge
  row_t   rows[$];
  entry_t fifo_q[$];
  entry_t pre_entry;
  logic   pre_valid = 1'b0;
  entry_t disp_entry;
  xlen_t  disp_rs1;
  xlen_t  disp_rs2;
  logic   disp_due = 1'b0;
  string  cur_name = "idle";
  logic   cur_accept = 1'b0;
  int     held_takes = 0;
  int     cycles = 0;
  int     cycle_limit = 200;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk  ),
    .rst_no (rst_n)
  );

  vec_issue_frontend DUT (
    .clk_i            (clk           ),
    .rst_ni           (rst_n         ),
    .issue_valid_i    (issue_valid   ),
    .issue_instr_i    (issue_instr   ),
    .issue_ready_o    (issue_ready   ),
    .issue_accept_o   (issue_accept  ),
    .register_valid_i (register_valid),
    .rs1_i            (rs1           ),
    .rs2_i            (rs2           ),
    .register_ready_o (register_ready),
    .dispatch_valid_o (dispatch_valid),
    .dispatch_instr_o (dispatch_instr),
    .dispatch_rs1_o   (dispatch_rs1  ),
    .dispatch_rs2_o   (dispatch_rs2  ),
    .flush_i          (flush         ),
    .flush_unissued_i (flush_unissued)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // Opcode in [6:0] and width field in [14:12]
  // Tag keeps words unique
  function automatic instr_t mk_instr(input logic [6:0] opc, input logic [2:0] width,
                                      input logic [7:0] tag);
    return {9'h0, tag, width, tag[4:0], opc};
  endfunction

  function automatic void add_row(input string name, input instr_t instr,
                                  input logic accept, input logic hold, input int action);
    rows.push_back(row_t'{name, instr, accept, hold, action,
                          {$urandom, $urandom}, {$urandom, $urandom}});
  endfunction

  function automatic void build_table();
    // Steady flow with operands offered all the time
    add_row("opv_add",    mk_instr(7'h57, 3'd1, 8'd1),  1'b1, 1'b0, ActNone);
    add_row("vle8",       mk_instr(7'h07, 3'd0, 8'd2),  1'b1, 1'b0, ActNone);
    add_row("flw",        mk_instr(7'h07, 3'd2, 8'd3),  1'b0, 1'b0, ActNone);
    add_row("vse16",      mk_instr(7'h27, 3'd5, 8'd4),  1'b1, 1'b0, ActNone);
    add_row("fsd",        mk_instr(7'h27, 3'd3, 8'd5),  1'b0, 1'b0, ActNone);
    add_row("scalar_add", mk_instr(7'h33, 3'd0, 8'd6),  1'b0, 1'b0, ActNone);
    add_row("vle32",      mk_instr(7'h07, 3'd6, 8'd7),  1'b1, 1'b0, ActDrain);
    // Back-pressure with five taken and one pop for the sixth
    add_row("vse64",      mk_instr(7'h27, 3'd7, 8'd8),  1'b1, 1'b1, ActNone);
    add_row("opv_sub",    mk_instr(7'h57, 3'd0, 8'd9),  1'b1, 1'b1, ActNone);
    add_row("fsw",        mk_instr(7'h27, 3'd2, 8'd10), 1'b0, 1'b1, ActNone);
    add_row("opv_and",    mk_instr(7'h57, 3'd2, 8'd11), 1'b1, 1'b1, ActNone);
    add_row("vle8_b",     mk_instr(7'h07, 3'd0, 8'd12), 1'b1, 1'b1, ActNone);
    add_row("opv_or",     mk_instr(7'h57, 3'd3, 8'd13), 1'b1, 1'b1, ActNone);
    add_row("opv_xor",    mk_instr(7'h57, 3'd4, 8'd14), 1'b1, 1'b1, ActDrain);
    // Full flush of queued work
    add_row("opv_min",    mk_instr(7'h57, 3'd5, 8'd15), 1'b1, 1'b1, ActNone);
    add_row("vle16_f",    mk_instr(7'h07, 3'd5, 8'd16), 1'b1, 1'b1, ActFlush);
    add_row("opv_max",    mk_instr(7'h57, 3'd6, 8'd17), 1'b1, 1'b0, ActDrain);
    // Pre-buffer flush only
    add_row("opv_sll",    mk_instr(7'h57, 3'd7, 8'd18), 1'b1, 1'b1, ActNone);
    add_row("vse32_u",    mk_instr(7'h27, 3'd6, 8'd19), 1'b1, 1'b1, ActNone);
    add_row("opv_srl",    mk_instr(7'h57, 3'd1, 8'd20), 1'b1, 1'b1, ActUniss);
    add_row("opv_sra",    mk_instr(7'h57, 3'd2, 8'd21), 1'b1, 1'b0, ActDrain);
  endfunction

  //////////////////////////////////////////////////
  // Reference model and output checks
  //////////////////////////////////////////////////

  always @(negedge clk) begin : model
    logic exp_ready;
    logic pop;
    logic push;
    if (rst_n) begin
      // Dispatch follows a pop by exactly one cycle
      check_bit({cur_name, " dispatch_valid"}, disp_due, dispatch_valid);
      if (disp_due) begin
        check_instr({disp_entry.name, " dispatch_instr"}, disp_entry.instr, dispatch_instr);
        check_xlen({disp_entry.name, " dispatch_rs1"}, disp_rs1, dispatch_rs1);
        check_xlen({disp_entry.name, " dispatch_rs2"}, disp_rs2, dispatch_rs2);
      end
      exp_ready = issue_valid && (fifo_q.size() < int'(FifoDepth)) && !flush;
      check_bit({cur_name, " issue_ready"}, exp_ready, issue_ready);
      check_bit({cur_name, " register_ready"}, fifo_q.size() != 0, register_ready);
      if (issue_valid) begin
        check_bit({cur_name, " issue_accept"}, cur_accept, issue_accept);
      end
      // Accepted handshakes seen on the DUT since its last pop
      if (register_valid && register_ready) begin
        held_takes = 0;
      end
      if (issue_valid && issue_ready && issue_accept) begin
        held_takes++;
      end
      pop  = register_valid && (fifo_q.size() != 0);
      push = pre_valid && (fifo_q.size() < int'(FifoDepth)) && !flush && !flush_unissued;
      disp_due = pop;
      if (pop) begin
        disp_entry = fifo_q.pop_front();
        disp_rs1   = rs1;
        disp_rs2   = rs2;
      end
      if (push) begin
        fifo_q.push_back(pre_entry);
        pre_valid = 1'b0;
      end
      if (exp_ready && cur_accept) begin
        pre_entry  = '{cur_name, issue_instr};
        pre_valid  = 1'b1;
      end
      if (flush || flush_unissued) begin
        pre_valid = 1'b0;
      end
      if (flush) begin
        fifo_q.delete();
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  // Starts and ends right after a rising edge
  task automatic run_row(input int i);
    int stall;
    stall          = 0;
    cur_name       = rows[i].name;
    cur_accept     = rows[i].accept;
    issue_valid    <= 1'b1;
    issue_instr    <= rows[i].instr;
    register_valid <= !rows[i].hold;
    rs1            <= rows[i].rs1;
    rs2            <= rows[i].rs2;
    @(negedge clk);
    while (!issue_ready) begin
      stall++;
      @(posedge clk);
      if (rows[i].hold && stall == 3) begin
        if (held_takes != MaxHeld) begin
          $display("Fail %s held takes: expected %0d, actual %0d",
                   cur_name, MaxHeld, held_takes);
          $display("*** FAILED ***");
          $fatal(1);
        end
        // Single pop to free one entry
        register_valid <= 1'b1;
      end else begin
        register_valid <= !rows[i].hold;
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic drain();
    issue_valid    <= 1'b0;
    register_valid <= 1'b1;
    do begin
      @(posedge clk);
    end while (fifo_q.size() != 0 || pre_valid || disp_due);
    register_valid <= 1'b0;
    held_takes     = 0;
  endtask

  task automatic pulse_flush(input logic full_flush);
    issue_valid    <= 1'b0;
    register_valid <= 1'b0;
    flush          <= full_flush;
    flush_unissued <= !full_flush;
    @(posedge clk);
    flush          <= 1'b0;
    flush_unissued <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h2a9c));
    issue_valid    = 1'b0;
    issue_instr    = '0;
    register_valid = 1'b0;
    rs1            = '0;
    rs2            = '0;
    flush          = 1'b0;
    flush_unissued = 1'b0;
    build_table();
    cycle_limit = rows.size() * 20 + 200;

    @(posedge rst_n);
    @(negedge clk);
    check_bit("reset issue_ready", 1'b0, issue_ready);
    check_bit("reset register_ready", 1'b0, register_ready);
    check_bit("reset dispatch_valid", 1'b0, dispatch_valid);

    @(posedge clk);
    foreach (rows[i]) begin
      run_row(i);
      case (rows[i].action)
        ActDrain: drain();
        ActFlush: pulse_flush(1'b1);
        ActUniss: pulse_flush(1'b0);
        default: begin
        end
      endcase
    end

    if (fifo_q.size() != 0 || pre_valid || disp_due) begin
      $display("Instructions were left undispatched at the end of the table");
      $display("*** FAILED ***");
      $fatal(1);
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule : tb_vec_issue

`default_nettype wire
